/* src/cache_settings.svh */
// geometry of the two-way data cache, included by the package and every RTL module
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// address split of a 32-bit CPU address
`define CACHE_TAG_W     20
`define CACHE_INDEX_W   8
`define CACHE_OFFSET_W  4

// sets per way
`define CACHE_SETS      256

// a line is four 32-bit banks
`define CACHE_BANKS     4
`define CACHE_WORD_W    32
`define CACHE_LINE_W    128

// victim LFSR start value, must not be zero
`define CACHE_LFSR_SEED 3'b111

`endif

/* src/cache_pkg.sv */
// shared types of the data cache: FSM states, address view and CPU/memory bundles
`include "cache_settings.svh"

package cache_pkg;

    // one-hot main FSM
    typedef enum logic [5:0] {
        IDLE     = 6'b000001,
        LOOKUP   = 6'b000010,
        HITWRITE = 6'b000100,
        MISS     = 6'b001000,
        REPLACE  = 6'b010000,
        REFILL   = 6'b100000
    } cache_state_e;

    typedef struct packed {
        logic [`CACHE_TAG_W-1:0]                             tag;
        logic [`CACHE_INDEX_W-1:0]                           index;
        logic [$clog2(`CACHE_BANKS)-1:0]                     bank;
        logic [`CACHE_OFFSET_W-$clog2(`CACHE_BANKS)-1:0]     byte_off;
    } addr_fields_t;

    // same 32 bits, seen as a bus address or split into fields
    typedef union packed {
        logic [`CACHE_TAG_W+`CACHE_INDEX_W+`CACHE_OFFSET_W-1:0] raw;
        addr_fields_t                                           f;
    } cache_addr_u;

    typedef struct packed {
        logic                       op;     // 1 = store
        cache_addr_u                addr;
        logic [`CACHE_WORD_W/8-1:0] wstrb;
        logic [`CACHE_WORD_W-1:0]   wdata;
    } cpu_req_t;

    // one refill beat from memory
    typedef struct packed {
        logic                     valid;
        logic                     last;
        logic [`CACHE_WORD_W-1:0] data;
    } mem_ret_t;

    typedef struct packed {
        logic [`CACHE_TAG_W-1:0] tag;
        logic                    valid;
    } tagv_t;

endpackage

/* src/miss_counters.sv */
// refill beat counter and pseudo-random victim way for the cache miss path
`timescale 1ns/1ps
`include "cache_settings.svh"

module miss_counters (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            refill,
    input  cache_pkg::mem_ret_t             ret,
    output logic [$clog2(`CACHE_BANKS)-1:0] beat,
    output logic                            victim_way
);
    import cache_pkg::*;

    logic [2:0] lfsr_q;
    logic       beat_valid;

    assign beat_valid = refill && ret.valid;

    // counts returned words, wraps to zero after the last one
    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat <= '0;
        end else if (beat_valid) begin
            beat <= beat + 1'b1;
        end
    end

    // 3-bit LFSR, period 7
    always_ff @(posedge clk) begin
        if (!resetn) begin
            lfsr_q <= `CACHE_LFSR_SEED;
        end else if (beat_valid && ret.last) begin
            lfsr_q <= {lfsr_q[0], lfsr_q[2] ^ lfsr_q[0], lfsr_q[1]};  // next victim
        end
    end

    assign victim_way = lfsr_q[0];

endmodule

/* src/tag_store.sv */
// tag/valid and dirty state of both cache ways, with hit compare and victim lookup
`timescale 1ns/1ps
`include "cache_settings.svh"

module tag_store (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            lookup,
    input  logic                            refill,
    input  logic                            hit_write,
    input  logic                            hit_way,
    input  cache_pkg::cpu_req_t             held_req,
    input  cache_pkg::cpu_req_t             req,
    input  logic [$clog2(`CACHE_BANKS)-1:0] beat,
    input  logic                            victim_way,
    input  cache_pkg::mem_ret_t             ret,
    output logic                            hit0,
    output logic                            hit1,
    output logic [`CACHE_TAG_W-1:0]         victim_tag,
    output logic                            victim_dirty
);
    import cache_pkg::*;

    tagv_t way_tv    [2];  // lookup result per way
    logic  way_dirty [2];

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic [`CACHE_TAG_W-1:0] tag_ram [`CACHE_SETS];
        logic [`CACHE_SETS-1:0]  valid_q;
        logic [`CACHE_SETS-1:0]  dirty_q;
        tagv_t                   rd_q;
        logic                    fill_tag;

        // tag goes in on the beat of the requested word
        assign fill_tag = refill && ret.valid && (hit_way == 1'(w)) &&
                          (beat == held_req.addr.f.bank);

        always_ff @(posedge clk) begin
            if (fill_tag) begin
                tag_ram[held_req.addr.f.index] <= held_req.addr.f.tag;
            end
            if (lookup) begin
                rd_q <= '{tag: tag_ram[req.addr.f.index], valid: valid_q[req.addr.f.index]};
            end
        end

        always_ff @(posedge clk) begin
            if (!resetn) begin
                valid_q <= '0;
                dirty_q <= '0;
            end else begin
                if (fill_tag) begin
                    valid_q[held_req.addr.f.index] <= 1'b1;
                end
                if (hit_write && (hit_way == 1'(w))) begin
                    dirty_q[held_req.addr.f.index] <= 1'b1;
                end else if (fill_tag) begin
                    // a store miss merges its bytes, so the fresh line is already dirty
                    dirty_q[held_req.addr.f.index] <= held_req.op;
                end
            end
        end

        assign way_tv[w]    = rd_q;
        assign way_dirty[w] = dirty_q[held_req.addr.f.index];
    end

    assign hit0 = way_tv[0].valid && (way_tv[0].tag == held_req.addr.f.tag);
    assign hit1 = way_tv[1].valid && (way_tv[1].tag == held_req.addr.f.tag);

    assign victim_tag   = way_tv[victim_way].tag;
    assign victim_dirty = way_tv[victim_way].valid && way_dirty[victim_way];  // needs write-back

endmodule

/* src/data_store.sv */
// data banks of both cache ways with byte writes, load select, refill merge and victim line
`timescale 1ns/1ps
`include "cache_settings.svh"

module data_store (
    input  logic                            clk,
    input  logic                            lookup,
    input  logic                            hit_write,
    input  logic                            refill,
    input  logic                            hit_way,
    input  cache_pkg::cpu_req_t             held_req,
    input  cache_pkg::cpu_req_t             req,
    input  logic [$clog2(`CACHE_BANKS)-1:0] beat,
    input  logic                            victim_way,
    input  cache_pkg::mem_ret_t             ret,
    output logic [`CACHE_WORD_W-1:0]        rdata,
    output logic [`CACHE_LINE_W-1:0]        victim_line
);
    import cache_pkg::*;

    localparam int BANK_W = $clog2(`CACHE_BANKS);
    localparam int STRB_W = `CACHE_WORD_W / 8;

    logic [`CACHE_WORD_W-1:0] way_line [2][`CACHE_BANKS];  // words read at lookup
    logic [`CACHE_WORD_W-1:0] fill_word;
    logic [`CACHE_WORD_W-1:0] wr_word;
    logic                     fill_en;
    logic                     merge_here;

    assign fill_en    = refill && ret.valid;
    assign merge_here = held_req.op && (beat == held_req.addr.f.bank);  // store miss beat

    always_comb begin
        for (int b = 0; b < STRB_W; b++) begin
            if (merge_here && held_req.wstrb[b]) begin
                fill_word[8*b +: 8] = held_req.wdata[8*b +: 8];
            end else begin
                fill_word[8*b +: 8] = ret.data[8*b +: 8];
            end
        end
    end

    assign wr_word = refill ? fill_word : held_req.wdata;

    for (genvar w = 0; w < 2; w++) begin : g_way
        for (genvar k = 0; k < `CACHE_BANKS; k++) begin : g_bank
            logic [`CACHE_WORD_W-1:0] bank_mem [`CACHE_SETS];
            logic [`CACHE_WORD_W-1:0] rd_q;
            logic [STRB_W-1:0]        be;

            // whole word on refill, strobed bytes on a store hit
            always_comb begin
                be = '0;
                if (hit_way == 1'(w)) begin
                    if (fill_en && (beat == BANK_W'(k))) begin
                        be = '1;
                    end else if (hit_write && (held_req.addr.f.bank == BANK_W'(k))) begin
                        be = held_req.wstrb;
                    end
                end
            end

            always_ff @(posedge clk) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (be[b]) begin
                        bank_mem[held_req.addr.f.index][8*b +: 8] <= wr_word[8*b +: 8];
                    end
                end
                if (lookup) begin
                    rd_q <= bank_mem[req.addr.f.index];  // new request index
                end
            end

            assign way_line[w][k] = rd_q;
        end
    end

    // refill forwards the returning beat straight to the CPU
    assign rdata = refill ? ret.data : way_line[hit_way][held_req.addr.f.bank];

    always_comb begin
        for (int k = 0; k < `CACHE_BANKS; k++) begin
            victim_line[`CACHE_WORD_W*k +: `CACHE_WORD_W] = way_line[victim_way][k];
        end
    end

endmodule

/* src/cache_ctrl.sv */
// main cache FSM with the request buffer; drives CPU and memory strobes and store controls
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_ctrl (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            valid,
    input  cache_pkg::cpu_req_t             req,
    input  logic                            hit0,
    input  logic                            hit1,
    input  logic                            victim_dirty,
    input  logic [`CACHE_TAG_W-1:0]         victim_tag,
    input  cache_pkg::mem_ret_t             ret,
    input  logic                            rd_rdy,
    input  logic                            wr_rdy,
    input  logic [$clog2(`CACHE_BANKS)-1:0] beat,
    input  logic                            victim_way,
    output logic                            addr_ok,
    output logic                            data_ok,
    output logic                            rd_req,
    output logic [31:0]                     rd_addr,
    output logic                            wr_req,
    output logic [31:0]                     wr_addr,
    output logic                            lookup,
    output logic                            hit_write,
    output logic                            refill,
    output logic                            hit_way,
    output cache_pkg::cpu_req_t             held_req
);
    import cache_pkg::*;

    cache_state_e state_q;
    cache_state_e state_d;
    logic         hit;
    logic         hit_way_q;   // way of a store hit, kept for HITWRITE
    logic         req_beat;
    cache_addr_u  rd_line;
    cache_addr_u  wr_line;

    assign hit      = hit0 | hit1;
    assign req_beat = ret.valid && (beat == held_req.addr.f.bank);  // requested word arriving

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (valid) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (!hit) begin
                    state_d = MISS;
                end else if (held_req.op) begin
                    state_d = HITWRITE;
                end else begin
                    state_d = IDLE;
                end
            end
            HITWRITE: state_d = IDLE;
            MISS: begin
                // clean or invalid victim leaves at once
                if (!wr_req || wr_rdy) begin
                    state_d = REPLACE;
                end
            end
            REPLACE: begin
                if (rd_rdy) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (ret.valid && ret.last) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // request buffer, loaded on acceptance
    always_ff @(posedge clk) begin
        if (lookup) begin
            held_req <= req;
        end
        if (state_q == LOOKUP) begin
            hit_way_q <= hit1;
        end
    end

    assign addr_ok   = (state_q == IDLE);
    assign lookup    = valid && addr_ok;
    assign hit_write = (state_q == HITWRITE);
    assign refill    = (state_q == REFILL);

    // way the stores address; on a miss it is the victim
    assign hit_way = (state_q == LOOKUP)   ? hit1 :
                     (state_q == HITWRITE) ? hit_way_q : victim_way;

    // stores complete in LOOKUP, loads on a hit or on their refill beat
    assign data_ok = ((state_q == LOOKUP) && (hit || held_req.op)) ||
                     (refill && !held_req.op && req_beat);

    assign rd_req = (state_q == REPLACE);
    assign wr_req = (state_q == MISS) && victim_dirty;

    // line addresses, offset zero
    always_comb begin
        rd_line.f = '{tag: held_req.addr.f.tag, index: held_req.addr.f.index,
                      bank: '0, byte_off: '0};
        wr_line.f = '{tag: victim_tag, index: held_req.addr.f.index,
                      bank: '0, byte_off: '0};
    end

    assign rd_addr = rd_line.raw;
    assign wr_addr = wr_line.raw;

endmodule

/* src/cache_top.sv */
// top of the two-way write-back data cache, connects FSM, miss counters and both stores
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_top (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     valid,
    input  cache_pkg::cpu_req_t      req,
    input  logic                     rd_rdy,
    input  cache_pkg::mem_ret_t      ret,
    input  logic                     wr_rdy,
    output logic                     addr_ok,
    output logic                     data_ok,
    output logic [`CACHE_WORD_W-1:0] rdata,
    output logic                     rd_req,
    output logic [31:0]              rd_addr,
    output logic                     wr_req,
    output logic [31:0]              wr_addr,
    output logic [`CACHE_LINE_W-1:0] wr_data
);
    import cache_pkg::*;

    logic                     hit0;
    logic                     hit1;
    logic                     victim_dirty;
    logic [`CACHE_TAG_W-1:0]  victim_tag;
    logic [$clog2(`CACHE_BANKS)-1:0] beat;
    logic                     victim_way;
    logic                     lookup;
    logic                     hit_write;
    logic                     refill;
    logic                     hit_way;
    cpu_req_t                 held_req;

    cache_ctrl u_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .valid        (valid),
        .req          (req),
        .hit0         (hit0),
        .hit1         (hit1),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .ret          (ret),
        .rd_rdy       (rd_rdy),
        .wr_rdy       (wr_rdy),
        .beat         (beat),
        .victim_way   (victim_way),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .wr_req       (wr_req),
        .wr_addr      (wr_addr),
        .lookup       (lookup),
        .hit_write    (hit_write),
        .refill       (refill),
        .hit_way      (hit_way),
        .held_req     (held_req)
    );

    miss_counters u_counters (
        .clk        (clk),
        .resetn     (resetn),
        .refill     (refill),
        .ret        (ret),
        .beat       (beat),
        .victim_way (victim_way)
    );

    tag_store u_tags (
        .clk          (clk),
        .resetn       (resetn),
        .lookup       (lookup),
        .refill       (refill),
        .hit_write    (hit_write),
        .hit_way      (hit_way),
        .held_req     (held_req),
        .req          (req),
        .beat         (beat),
        .victim_way   (victim_way),
        .ret          (ret),
        .hit0         (hit0),
        .hit1         (hit1),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty)
    );

    // victim line feeds the write-back port directly
    data_store u_data (
        .clk         (clk),
        .lookup      (lookup),
        .hit_write   (hit_write),
        .refill      (refill),
        .hit_way     (hit_way),
        .held_req    (held_req),
        .req         (req),
        .beat        (beat),
        .victim_way  (victim_way),
        .ret         (ret),
        .rdata       (rdata),
        .victim_line (wr_data)
    );

endmodule

/* test/cache_checker.sv */
// testbench monitor that keeps a shadow memory of the cache_top traffic and checks its ports
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_checker #(
    parameter logic [31:0] init_xor = 32'h0
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     valid,
    input  cache_pkg::cpu_req_t      req,
    input  logic [`CACHE_WORD_W-1:0] exp_rdata,
    input  logic                     addr_ok,
    input  logic                     data_ok,
    input  logic [`CACHE_WORD_W-1:0] rdata,
    input  logic                     rd_req,
    input  logic [31:0]              rd_addr,
    input  logic                     rd_rdy,
    input  logic                     wr_req,
    input  logic [31:0]              wr_addr,
    input  logic [`CACHE_LINE_W-1:0] wr_data,
    input  logic                     wr_rdy,
    output int                       value_errs,
    output int                       proto_errs
);
    import cache_pkg::*;

    logic [31:0]              shadow [logic [31:0]];  // by word address
    bit                       written [logic [27:0]]; // lines stored to since write-back
    logic [31:0]              acc_addr;
    logic [31:0]              acc_exp;
    logic                     acc_op;
    bit                       busy, missed, seen_req, rd_wait, wr_wait;
    int                       lat;
    logic [31:0]              rd_addr_q, wr_addr_q;
    logic [`CACHE_LINE_W-1:0] wr_data_q;
    logic [27:0]              last_line;
    bit                       last_ok;
    bit                       must_hit;

    function automatic logic [31:0] shadow_word(logic [31:0] a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a ^ init_xor;  // never written so still the initial pattern
    endfunction

    task automatic value_err(string msg);
        $display("ERR %0t: %s", $time, msg);
        value_errs++;
    endtask

    task automatic proto_err(string msg);
        $display("ERR %0t: %s", $time, msg);
        proto_errs++;
    endtask

    initial begin
        value_errs = 0;
        proto_errs = 0;
    end

    always @(posedge clk) begin
        logic [31:0] w;
        if (!resetn) begin
            busy = 0;
            seen_req = 0;
            rd_wait = 0;
            wr_wait = 0;
            last_ok = 0;
            must_hit = 0;
        end else begin
            if (!seen_req && (!addr_ok || data_ok || rd_req || wr_req)) begin
                proto_err("outputs not idle after reset");
            end
            if (rd_wait && (!rd_req || rd_addr != rd_addr_q)) begin
                proto_err("rd_req or rd_addr changed while rd_rdy low");
            end
            if (wr_wait && (!wr_req || wr_addr != wr_addr_q || wr_data != wr_data_q)) begin
                proto_err("wr_req, wr_addr or wr_data changed while wr_rdy low");
            end
            rd_wait   = rd_req && !rd_rdy;
            wr_wait   = wr_req && !wr_rdy;
            rd_addr_q = rd_addr;
            wr_addr_q = wr_addr;
            wr_data_q = wr_data;
            if (busy) lat++;
            if (rd_req && rd_rdy) begin
                missed = 1;
                if (must_hit) begin
                    proto_err($sformatf("refill of line %h right after an access to it",
                                        rd_addr));
                end
                if (rd_addr != {acc_addr[31:4], 4'h0}) begin
                    value_err($sformatf("rd_addr %h for request %h", rd_addr, acc_addr));
                end
            end
            if (wr_req && wr_rdy) begin
                if (!written.exists(wr_addr[31:4])) begin
                    proto_err($sformatf("write-back of unwritten line %h", wr_addr));
                end else begin
                    for (int k = 0; k < `CACHE_BANKS; k++) begin
                        w = shadow_word(wr_addr + 32'(4 * k));
                        if (wr_data[32*k +: 32] != w) begin
                            value_err($sformatf("wr_data word %0d %h, expected %h",
                                                k, wr_data[32*k +: 32], w));
                        end
                    end
                    written.delete(wr_addr[31:4]);
                end
            end
            if (data_ok) begin
                if (!busy) begin
                    proto_err("data_ok without a request");
                end else begin
                    if (!acc_op && rdata != acc_exp) begin
                        value_err($sformatf("read %h gave %h, file expects %h",
                                            acc_addr, rdata, acc_exp));
                    end
                    if (!acc_op && rdata != shadow_word(acc_addr)) begin
                        value_err($sformatf("read %h gave %h, shadow holds %h",
                                            acc_addr, rdata, shadow_word(acc_addr)));
                    end
                    if ((acc_op || !missed) && lat != 1) begin
                        value_err($sformatf("data_ok %0d cycles after acceptance", lat));
                    end
                    busy = 0;
                end
            end
            if (valid && addr_ok) begin
                seen_req  = 1;
                busy      = 1;
                lat       = 0;
                missed    = 0;
                must_hit  = last_ok && (req.addr.raw[31:4] == last_line);  // still cached
                last_line = req.addr.raw[31:4];
                last_ok   = 1;
                acc_op    = req.op;
                acc_addr  = {req.addr.raw[31:2], 2'b00};
                acc_exp   = exp_rdata;
                if (req.op) begin
                    w = shadow_word(acc_addr);
                    for (int b = 0; b < 4; b++) begin
                        if (req.wstrb[b]) w[8*b +: 8] = req.wdata[8*b +: 8];
                    end
                    shadow[acc_addr]          = w;
                    written[acc_addr[31:4]]   = 1;
                end
            end
        end
    end

endmodule

/* test/tb_cache.sv */
// testbench for cache_top that replays file requests against a memory model with random stalls
`timescale 1ns/1ps
`include "cache_settings.svh"

module tb_cache;
    import cache_pkg::*;

    localparam logic [31:0] mem_xor = 32'hc0de0000;  // initial word = address ^ mem_xor
    localparam int          timeout = 200;

    logic clk = 0, resetn, valid, rd_rdy, wr_rdy, addr_ok, data_ok, rd_req, wr_req;
    cpu_req_t                 req;
    mem_ret_t                 ret;
    logic [`CACHE_WORD_W-1:0] rdata, exp_rdata;
    logic [31:0]              rd_addr, wr_addr, line_addr;
    logic [`CACHE_LINE_W-1:0] wr_data;
    logic [31:0]              mem [logic [31:0]];
    logic [31:0]              lfsr_q = 32'hb36a;
    int                       mstate, cnt, beat_n, fd, value_errs, proto_errs;
    bit                       aborted, expired;
    logic [31:0]              f_op, f_addr, f_strb, f_wdata, f_exp;
    string                    line_s;

    always #5 clk = ~clk;

    cache_top u_dut (.*);

    cache_checker #(.init_xor(mem_xor)) u_check (.*);

    // galois lfsr stepped once per bit taken
    function automatic int rand_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_q[0]);
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] mem_word(logic [31:0] a);
        return mem.exists(a) ? mem[a] : (a ^ mem_xor);
    endfunction

    // memory model states 0 idle, 1 write delay, 2 read delay, 3 return beats
    always @(negedge clk) begin
        rd_rdy = 0;
        wr_rdy = 0;
        ret    = '0;
        if (resetn) begin
            case (mstate)
                0: begin
                    cnt = rand_bits(2);
                    if (wr_req) mstate = 1;
                    else if (rd_req) mstate = 2;
                end
                1: begin
                    if (cnt == 0) begin
                        wr_rdy = 1;
                        for (int k = 0; k < 4; k++) begin
                            mem[wr_addr + 32'(4 * k)] = wr_data[32*k +: 32];
                        end
                        mstate = 0;
                    end else cnt--;
                end
                2: begin
                    if (cnt == 0) begin
                        rd_rdy    = 1;
                        line_addr = rd_addr;
                        beat_n    = 0;
                        mstate    = 3;
                    end else cnt--;
                end
                default: begin
                    if (rand_bits(1) == 0) begin  // otherwise a gap cycle
                        ret.valid = 1;
                        ret.last  = (beat_n == 3);
                        ret.data  = mem_word(line_addr + 32'(4 * beat_n));
                        if (beat_n == 3) mstate = 0;
                        beat_n++;
                    end
                end
            endcase
        end
    end

    task automatic wait_addr_ok(output bit exp);
        int n;
        n = 0;
        while (!addr_ok && n < timeout) begin
            @(negedge clk);
            n++;
        end
        exp = !addr_ok;
        if (exp) $display("timeout while waiting for addr_ok");
    endtask

    // data_ok follows the returned beat, so it is looked at on the rising edge
    task automatic wait_data_ok(output bit exp);
        int n;
        bit seen;
        n = 0;
        seen = 0;
        while (!seen && n < timeout) begin
            @(posedge clk);
            seen = data_ok;
            n++;
        end
        exp = !seen;
        if (exp) $display("timeout while waiting for data_ok");
    endtask

    initial begin
        resetn = 0;
        valid = 0;
        req = '0;
        exp_rdata = '0;
        rd_rdy = 0;
        wr_rdy = 0;
        ret = '0;
        mstate = 0;
        aborted = 0;
        repeat (4) @(negedge clk);
        resetn = 1;
        @(negedge clk);
        fd = $fopen("test/cache_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file test/cache_input.txt");
            aborted = 1;
        end
        while (!aborted && !$feof(fd)) begin
            void'($fgets(line_s, fd));
            if ($sscanf(line_s, "%h %h %h %h %h",
                        f_op, f_addr, f_strb, f_wdata, f_exp) == 5) begin
                wait_addr_ok(expired);
                if (expired) begin
                    aborted = 1;
                end else begin
                    valid         = 1;
                    req.op        = f_op[0];
                    req.addr.raw  = f_addr;
                    req.wstrb     = f_strb[3:0];
                    req.wdata     = f_wdata;
                    exp_rdata     = f_exp;
                    @(negedge clk);  // accepted on the edge in between
                    valid = 0;
                    wait_data_ok(expired);
                    aborted = expired;
                    @(negedge clk);
                end
            end
        end
        if (!aborted) begin
            wait_addr_ok(expired);
            aborted = expired;
        end
        $display("errors: value %0d, protocol %0d", value_errs, proto_errs);
        if (!aborted && value_errs == 0 && proto_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+src
src/cache_pkg.sv
src/miss_counters.sv
src/tag_store.sv
src/data_store.sv
src/cache_ctrl.sv
src/cache_top.sv
test/cache_checker.sv
test/tb_cache.sv

/* Makefile */
SRCS := $(wildcard src/*.sv src/*.svh test/*.sv)

obj_dir/Vtb_cache: all.f $(SRCS)
	verilator --binary --timing -f all.f --top-module tb_cache -o Vtb_cache

run: obj_dir/Vtb_cache
	obj_dir/Vtb_cache | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* test/cache_input.txt */
# op(1=store) address strobe wdata expected_rdata, all hex
# expected is checked on loads only; initial memory word = address ^ c0de0000
0 00001044 0 00000000 c0de1044
0 00001044 0 00000000 c0de1044
0 0000104c 0 00000000 c0de104c
1 00001048 3 aabbccdd 00000000
0 00001048 0 00000000 c0deccdd
1 00005108 c 11223344 00000000
0 00005108 0 00000000 11225108
0 0000510c 0 00000000 c0de510c
0 00002040 0 00000000 c0de2040
1 00002044 f 01020304 00000000
0 00003040 0 00000000 c0de3040
0 00001048 0 00000000 c0deccdd
0 00002044 0 00000000 01020304
1 0000304c 1 000000ee 00000000
0 00001040 0 00000000 c0de1040
0 0000304c 0 00000000 c0de30ee
0 00002048 0 00000000 c0de2048
1 00001040 8 77000000 00000000
0 00003044 0 00000000 c0de3044
0 00001040 0 00000000 77de1040
0 00002044 0 00000000 01020304
0 0000304c 0 00000000 c0de30ee
